// File: hw/engine_ctrl_settings.svh
/* Register map and field widths of the engine host interface.
   Indices are 32-bit word numbers, i.e. byte address bits 15:2. */
`ifndef ENGINE_CTRL_SETTINGS_SVH
`define ENGINE_CTRL_SETTINGS_SVH

`define CTRL_ADDR_WIDTH    16
`define REG_INDEX_WIDTH    14
`define ROW_WIDTH          32  // 8 squares of 4 bits
`define BOARD_ROWS         8
`define EVAL_WIDTH         24
`define HALF_MOVE_WIDTH    8
`define MOVE_INDEX_WIDTH   7
`define TRANS_NODES_WIDTH  24

`define REG_CTRL           0
`define REG_MOVE_INDEX     1
`define REG_POSITION       2
`define REG_HALF_MOVE      3
`define REG_QUIESCENCE     4
`define REG_BOARD_BASE     8   // Rows 8 to 15

`define REG_AM_FLAGS       132
`define REG_AM_POSITION    133
`define REG_AM_EVAL        134
`define REG_AM_MOVE_COUNT  135
`define REG_INITIAL_EVAL   136
`define REG_AM_BOARD_BASE  172 // Rows 172 to 179

`define REG_TRANS_STATUS   512
`define REG_TRANS_EVAL_IN  514
`define REG_TRANS_NODES_IN 515
`define REG_TRANS_CMD      520
`define REG_TRANS_EVAL     521
`define REG_TRANS_NODES    525

`endif

// File: hw/engine_ctrl_pkg.sv
/* Types shared by the host register block. Register words are decoded
   by index through reg_word_u, the same way on write and on read. */
`include "engine_ctrl_settings.svh"

package engine_ctrl_pkg;

   typedef logic [`BOARD_ROWS-1:0][`ROW_WIDTH-1:0] board_t;

   typedef struct packed {
      logic       white_to_move;
      logic [3:0] castle_mask;
      logic [3:0] en_passant_col;
   } position_t;

   typedef struct packed {
      logic        soft_reset;
      logic [28:0] status;  // Read-only engine status from bit 2
      logic        clear_moves;
      logic        new_board_valid;
   } ctrl_word_t;

   typedef struct packed {
      logic [22:0] rsvd;
      position_t   position;
   } pos_word_t;

   typedef struct packed {
      logic [15:0] rsvd_hi;
      logic [7:0]  depth;
      logic [1:0]  rsvd_lo;
      logic        clear;
      logic        hash_only;
      logic [1:0]  flag;
      logic        store;
      logic        lookup;
   } trans_cmd_word_t;

   typedef union packed {
      logic [31:0]     raw;
      ctrl_word_t      ctrl;
      pos_word_t       pos;
      trans_cmd_word_t trans_cmd;
   } reg_word_u;

   typedef struct packed {
      logic                        valid;
      logic [`REG_INDEX_WIDTH-1:0] index;
      reg_word_u                   data;
   } reg_wr_t;

   typedef struct packed {
      logic                         new_board_valid;
      logic                         clear_moves;
      logic                         quiescence;
      logic [`MOVE_INDEX_WIDTH-1:0] move_index;
      position_t                    position;
      logic [`HALF_MOVE_WIDTH-1:0]  half_move;
      board_t                       board;
   } board_setup_t;

   typedef struct packed {
      logic moves_ready;
      logic move_ready;
      logic idle;
      logic mate;
      logic stalemate;
      logic thrice_rep;
      logic fifty_move;
      logic insufficient_material;
      logic board_check;
   } game_status_t;

   typedef struct packed {
      board_t                       board;
      position_t                    position;
      logic                         capture;
      logic                         white_in_check;
      logic                         black_in_check;
      logic                         thrice_rep;
      logic                         fifty_move;
      logic                         insufficient_material;
      logic                         pv;
      logic [`EVAL_WIDTH-1:0]       eval;  // Two's complement
      logic [`MOVE_INDEX_WIDTH-1:0] move_count;
      logic [`EVAL_WIDTH-1:0]       initial_eval;
   } move_info_t;

   typedef struct packed {
      logic                          lookup;
      logic                          store;
      logic [1:0]                    flag;
      logic                          hash_only;
      logic                          clear;
      logic [7:0]                    depth;
      logic                          capture;
      logic [`EVAL_WIDTH-1:0]        eval;
      logic [`TRANS_NODES_WIDTH-1:0] nodes;
   } trans_cmd_t;

   typedef struct packed {
      logic                          entry_valid;
      logic                          idle;
      logic                          collision;
      logic                          capture;
      logic [1:0]                    flag;
      logic [7:0]                    depth;
      logic [`EVAL_WIDTH-1:0]        eval;
      logic [`TRANS_NODES_WIDTH-1:0] nodes;
   } trans_result_t;

   typedef struct packed {
      logic [`CTRL_ADDR_WIDTH-1:0] awaddr;
      logic                        awvalid;
      logic [31:0]                 wdata;
      logic [3:0]                  wstrb;
      logic                        wvalid;
      logic                        bready;
   } axil_wr_req_t;

   typedef struct packed {
      logic       awready;
      logic       wready;
      logic [1:0] bresp;
      logic       bvalid;
   } axil_wr_rsp_t;

   typedef struct packed {
      logic [`CTRL_ADDR_WIDTH-1:0] araddr;
      logic                        arvalid;
      logic                        rready;
   } axil_rd_req_t;

   typedef struct packed {
      logic        arready;
      logic [31:0] rdata;
      logic [1:0]  rresp;
      logic        rvalid;
   } axil_rd_rsp_t;

endpackage

// File: hw/axil_write_port.sv
/* AXI4-Lite write slave, one write in flight. wstrb is ignored and
   bresp is always OKAY; address and data beats may come in any order. */
`timescale 1ns/100ps
`include "engine_ctrl_settings.svh"

module axil_write_port import engine_ctrl_pkg::*;
(
   input  logic         clk,
   input  logic         rst,
   input  axil_wr_req_t wr_req,
   output axil_wr_rsp_t wr_rsp,
   output reg_wr_t      reg_wr
);

   logic                        aw_held;
   logic                        w_held;
   logic                        bvalid;
   logic                        cmd_valid;
   logic [`REG_INDEX_WIDTH-1:0] wr_index;
   reg_word_u                   wr_data;

   assign wr_rsp.awready = !aw_held;
   assign wr_rsp.wready  = !w_held;
   assign wr_rsp.bresp   = 2'b00;
   assign wr_rsp.bvalid  = bvalid;

   always_comb
   begin
      reg_wr.valid = cmd_valid;
      reg_wr.index = wr_index;
      reg_wr.data  = wr_data;
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         aw_held   <= 1'b0;
         w_held    <= 1'b0;
         bvalid    <= 1'b0;
         cmd_valid <= 1'b0;
      end
      else
      begin
         cmd_valid <= 1'b0;
         if (wr_req.awvalid && !aw_held)
            aw_held <= 1'b1;
         if (wr_req.wvalid && !w_held)
            w_held <= 1'b1;
         if (aw_held && w_held && !bvalid)
         begin
            cmd_valid <= 1'b1;  // Response raised with the command
            bvalid    <= 1'b1;
         end
         if (bvalid && wr_req.bready)
         begin
            aw_held <= 1'b0;
            w_held  <= 1'b0;
            bvalid  <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (wr_req.awvalid && !aw_held)
         wr_index <= wr_req.awaddr[`CTRL_ADDR_WIDTH-1:2];  // Byte to word
      if (wr_req.wvalid && !w_held)
         wr_data.raw <= wr_req.wdata;
   end

   a_cmd_single: assert property (@(posedge clk) disable iff (rst)
      reg_wr.valid |=> !reg_wr.valid);

   a_bvalid_hold: assert property (@(posedge clk) disable iff (rst)
      wr_rsp.bvalid && !wr_req.bready |=> wr_rsp.bvalid);

endmodule

// File: hw/board_setup_regs.sv
/* Starting position and move selection registers for the move generator.
   new_board_valid and clear_moves are levels, cleared only by software. */
`timescale 1ns/100ps
`include "engine_ctrl_settings.svh"

module board_setup_regs import engine_ctrl_pkg::*;
(
   input  logic         clk,
   input  logic         rst,
   input  reg_wr_t      reg_wr,
   output board_setup_t setup,
   output logic         soft_reset
);

   localparam int ROW_SEL_WIDTH = $clog2(`BOARD_ROWS);

   logic [`REG_INDEX_WIDTH-1:0] row_offset;
   logic                        row_hit;

   // Wraps high below the base, so one compare covers both ends
   assign row_offset = reg_wr.index - `REG_INDEX_WIDTH'(`REG_BOARD_BASE);
   assign row_hit    = row_offset < `REG_INDEX_WIDTH'(`BOARD_ROWS);

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         setup      <= '0;
         soft_reset <= 1'b0;
      end
      else if (reg_wr.valid)
      begin
         case (reg_wr.index)
            `REG_CTRL:
            begin
               setup.new_board_valid <= reg_wr.data.ctrl.new_board_valid;
               setup.clear_moves     <= reg_wr.data.ctrl.clear_moves;
               soft_reset            <= reg_wr.data.ctrl.soft_reset;
            end
            `REG_MOVE_INDEX:
               setup.move_index <= reg_wr.data.raw[`MOVE_INDEX_WIDTH-1:0];
            `REG_POSITION:
               setup.position <= reg_wr.data.pos.position;
            `REG_HALF_MOVE:
               setup.half_move <= reg_wr.data.raw[`HALF_MOVE_WIDTH-1:0];
            `REG_QUIESCENCE:
               setup.quiescence <= reg_wr.data.raw[0];
            default:
            begin
               if (row_hit)
                  setup.board[row_offset[ROW_SEL_WIDTH-1:0]] <= reg_wr.data.raw;
            end
         endcase
      end
   end

endmodule

// File: hw/trans_cmd_regs.sv
/* Transposition table command levels. Lookup, store and clear are held
   as written, so software writes them back to 0 itself. */
`timescale 1ns/100ps
`include "engine_ctrl_settings.svh"

module trans_cmd_regs import engine_ctrl_pkg::*;
(
   input  logic       clk,
   input  logic       rst,
   input  reg_wr_t    reg_wr,
   output trans_cmd_t trans_cmd
);

   always_ff @(posedge clk)
   begin
      if (rst)
         trans_cmd <= '0;
      else if (reg_wr.valid)
      begin
         case (reg_wr.index)
            `REG_TRANS_CMD:
            begin
               trans_cmd.lookup    <= reg_wr.data.trans_cmd.lookup;
               trans_cmd.store     <= reg_wr.data.trans_cmd.store;
               trans_cmd.flag      <= reg_wr.data.trans_cmd.flag;
               trans_cmd.hash_only <= reg_wr.data.trans_cmd.hash_only;
               trans_cmd.clear     <= reg_wr.data.trans_cmd.clear;
               trans_cmd.depth     <= reg_wr.data.trans_cmd.depth;
            end
            `REG_TRANS_EVAL:
            begin
               trans_cmd.capture <= reg_wr.data.raw[31];  // Shares word with eval
               trans_cmd.eval    <= reg_wr.data.raw[`EVAL_WIDTH-1:0];
            end
            `REG_TRANS_NODES:
               trans_cmd.nodes <= reg_wr.data.raw[`TRANS_NODES_WIDTH-1:0];
            default:
            begin
            end
         endcase
      end
   end

endmodule

// File: hw/reg_read_port.sv
/* AXI4-Lite read slave with registered data. The host must not present
   a new address while rvalid is high and rready is low. */
`timescale 1ns/100ps
`include "engine_ctrl_settings.svh"

module reg_read_port import engine_ctrl_pkg::*;
(
   input  logic          clk,
   input  logic          rst,
   input  axil_rd_req_t  rd_req,
   output axil_rd_rsp_t  rd_rsp,
   input  board_setup_t  setup,
   input  logic          soft_reset,
   input  game_status_t  status,
   input  move_info_t    move_info,
   input  trans_cmd_t    trans_cmd,
   input  trans_result_t trans_result
);

   localparam int ROW_SEL_WIDTH = $clog2(`BOARD_ROWS);

   logic [`REG_INDEX_WIDTH-1:0] rd_index;
   logic [`REG_INDEX_WIDTH-1:0] setup_row;
   logic [`REG_INDEX_WIDTH-1:0] am_row;
   reg_word_u                   rd_word;
   logic [31:0]                 rdata;
   logic                        rvalid;

   function automatic logic [31:0] sext_eval(input logic [`EVAL_WIDTH-1:0] v);
      return {{(32 - `EVAL_WIDTH){v[`EVAL_WIDTH-1]}}, v};
   endfunction

   assign rd_index  = rd_req.araddr[`CTRL_ADDR_WIDTH-1:2];
   assign setup_row = rd_index - `REG_INDEX_WIDTH'(`REG_BOARD_BASE);
   assign am_row    = rd_index - `REG_INDEX_WIDTH'(`REG_AM_BOARD_BASE);

   assign rd_rsp.arready = 1'b1;
   assign rd_rsp.rresp   = 2'b00;
   assign rd_rsp.rdata   = rdata;
   assign rd_rsp.rvalid  = rvalid;

   always_comb
   begin
      rd_word = '0;  // Unmapped and unused bits read 0
      case (rd_index)
         `REG_CTRL:
         begin
            rd_word.ctrl.new_board_valid = setup.new_board_valid;
            rd_word.ctrl.clear_moves     = setup.clear_moves;
            rd_word.ctrl.soft_reset      = soft_reset;
            rd_word.ctrl.status          = {20'b0, status.board_check,
               status.insufficient_material, status.fifty_move, status.idle,
               status.thrice_rep, status.mate, status.stalemate,
               status.move_ready, status.moves_ready};
         end
         `REG_MOVE_INDEX:    rd_word.raw = 32'(setup.move_index);
         `REG_POSITION:      rd_word.pos.position = setup.position;
         `REG_HALF_MOVE:     rd_word.raw = 32'(setup.half_move);
         `REG_QUIESCENCE:    rd_word.raw = 32'(setup.quiescence);
         `REG_AM_FLAGS:
            rd_word.raw = 32'({move_info.pv, move_info.insufficient_material,
               move_info.fifty_move, move_info.thrice_rep,
               move_info.black_in_check, move_info.white_in_check,
               move_info.capture});
         `REG_AM_POSITION:   rd_word.pos.position = move_info.position;
         `REG_AM_EVAL:       rd_word.raw = sext_eval(move_info.eval);
         `REG_AM_MOVE_COUNT: rd_word.raw = 32'(move_info.move_count);
         `REG_INITIAL_EVAL:  rd_word.raw = sext_eval(move_info.initial_eval);
         `REG_TRANS_STATUS:
            rd_word.raw = {14'b0, trans_result.capture, trans_result.collision,
               trans_result.depth, 4'b0, trans_result.flag,
               trans_result.entry_valid, trans_result.idle};
         `REG_TRANS_EVAL_IN:  rd_word.raw = sext_eval(trans_result.eval);
         `REG_TRANS_NODES_IN: rd_word.raw = 32'(trans_result.nodes);
         `REG_TRANS_CMD:
         begin
            rd_word.trans_cmd.lookup    = trans_cmd.lookup;
            rd_word.trans_cmd.store     = trans_cmd.store;
            rd_word.trans_cmd.flag      = trans_cmd.flag;
            rd_word.trans_cmd.hash_only = trans_cmd.hash_only;
            rd_word.trans_cmd.clear     = trans_cmd.clear;
            rd_word.trans_cmd.depth     = trans_cmd.depth;
         end
         // Capture in bit 31 where the sign would go
         `REG_TRANS_EVAL:  rd_word.raw = {trans_cmd.capture, 7'b0, trans_cmd.eval};
         `REG_TRANS_NODES: rd_word.raw = 32'(trans_cmd.nodes);
         default:
         begin
            if (setup_row < `REG_INDEX_WIDTH'(`BOARD_ROWS))
               rd_word.raw = setup.board[setup_row[ROW_SEL_WIDTH-1:0]];
            else if (am_row < `REG_INDEX_WIDTH'(`BOARD_ROWS))
               rd_word.raw = move_info.board[am_row[ROW_SEL_WIDTH-1:0]];
         end
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (rst)
         rvalid <= 1'b0;
      else if (rd_req.arvalid)
         rvalid <= 1'b1;
      else if (rd_req.rready)
         rvalid <= 1'b0;
   end

   always_ff @(posedge clk)
   begin
      if (rd_req.arvalid)
         rdata <= rd_word.raw;
   end

   a_no_ar_on_stall: assert property (@(posedge clk) disable iff (rst)
      rd_rsp.rvalid && !rd_req.rready |-> !rd_req.arvalid);

endmodule

// File: hw/engine_ctrl_top.sv
/* Host register block of the search engine, AXI4-Lite slave.
   Write and read channels are independent, one transaction each. */
`timescale 1ns/100ps

module engine_ctrl_top import engine_ctrl_pkg::*;
(
   input  logic          clk,
   input  logic          rst,
   input  axil_wr_req_t  wr_req,
   input  axil_rd_req_t  rd_req,
   output axil_wr_rsp_t  wr_rsp,
   output axil_rd_rsp_t  rd_rsp,
   input  game_status_t  status,
   input  move_info_t    move_info,
   input  trans_result_t trans_result,
   output board_setup_t  setup,
   output logic          soft_reset,
   output trans_cmd_t    trans_cmd
);

   reg_wr_t reg_wr;  // Single-cycle register write

   axil_write_port u_write_port (
      .clk    (clk),
      .rst    (rst),
      .wr_req (wr_req),
      .wr_rsp (wr_rsp),
      .reg_wr (reg_wr)
   );

   board_setup_regs u_board_setup (
      .clk        (clk),
      .rst        (rst),
      .reg_wr     (reg_wr),
      .setup      (setup),
      .soft_reset (soft_reset)
   );

   trans_cmd_regs u_trans_cmd (
      .clk       (clk),
      .rst       (rst),
      .reg_wr    (reg_wr),
      .trans_cmd (trans_cmd)
   );

   reg_read_port u_read_port (
      .clk          (clk),
      .rst          (rst),
      .rd_req       (rd_req),
      .rd_rsp       (rd_rsp),
      .setup        (setup),
      .soft_reset   (soft_reset),
      .status       (status),
      .move_info    (move_info),
      .trans_cmd    (trans_cmd),
      .trans_result (trans_result)
   );

endmodule

// File: verif/engine_ctrl_model.svh
/* Shadow of the writable registers and the expected read words.
   Included inside the testbench module, reads its input signals. */
`ifndef ENGINE_CTRL_MODEL_SVH
`define ENGINE_CTRL_MODEL_SVH

board_setup_t exp_setup;
logic         exp_soft_reset;
trans_cmd_t   exp_trans_cmd;

function automatic void model_reset();
   exp_setup      = '0;
   exp_soft_reset = 1'b0;
   exp_trans_cmd  = '0;
endfunction

function automatic void model_write(input int index, input logic [31:0] d);
   case (index)
      `REG_CTRL:
      begin
         exp_setup.new_board_valid = d[0];
         exp_setup.clear_moves     = d[1];
         exp_soft_reset            = d[31];
      end
      `REG_MOVE_INDEX:  exp_setup.move_index = d[`MOVE_INDEX_WIDTH-1:0];
      `REG_POSITION:
      begin
         exp_setup.position.white_to_move  = d[8];
         exp_setup.position.castle_mask    = d[7:4];
         exp_setup.position.en_passant_col = d[3:0];
      end
      `REG_HALF_MOVE:   exp_setup.half_move = d[`HALF_MOVE_WIDTH-1:0];
      `REG_QUIESCENCE:  exp_setup.quiescence = d[0];
      `REG_TRANS_CMD:
      begin
         exp_trans_cmd.lookup    = d[0];
         exp_trans_cmd.store     = d[1];
         exp_trans_cmd.flag      = d[3:2];
         exp_trans_cmd.hash_only = d[4];
         exp_trans_cmd.clear     = d[5];
         exp_trans_cmd.depth     = d[15:8];
      end
      `REG_TRANS_EVAL:
      begin
         exp_trans_cmd.capture = d[31];
         exp_trans_cmd.eval    = d[`EVAL_WIDTH-1:0];
      end
      `REG_TRANS_NODES: exp_trans_cmd.nodes = d[`TRANS_NODES_WIDTH-1:0];
      default:
      begin
         if (index >= `REG_BOARD_BASE && index < `REG_BOARD_BASE + `BOARD_ROWS)
            exp_setup.board[index - `REG_BOARD_BASE] = d;
      end
   endcase
endfunction

function automatic reg_word_u expected_read(input int index);
   reg_word_u   r;
   logic [31:0] w;
   w = '0;
   case (index)
      `REG_CTRL:
         w = {exp_soft_reset, 20'b0, status.board_check, status.insufficient_material,
              status.fifty_move, status.idle, status.thrice_rep, status.mate,
              status.stalemate, status.move_ready, status.moves_ready,
              exp_setup.clear_moves, exp_setup.new_board_valid};
      `REG_MOVE_INDEX:     w[`MOVE_INDEX_WIDTH-1:0] = exp_setup.move_index;
      `REG_POSITION:       w[8:0] = exp_setup.position;
      `REG_HALF_MOVE:      w[`HALF_MOVE_WIDTH-1:0] = exp_setup.half_move;
      `REG_QUIESCENCE:     w[0] = exp_setup.quiescence;
      `REG_AM_FLAGS:
         w[6:0] = {move_info.pv, move_info.insufficient_material, move_info.fifty_move,
                   move_info.thrice_rep, move_info.black_in_check,
                   move_info.white_in_check, move_info.capture};
      `REG_AM_POSITION:    w[8:0] = move_info.position;
      `REG_AM_EVAL:        w = 32'($signed(move_info.eval));
      `REG_AM_MOVE_COUNT:  w[`MOVE_INDEX_WIDTH-1:0] = move_info.move_count;
      `REG_INITIAL_EVAL:   w = 32'($signed(move_info.initial_eval));
      `REG_TRANS_STATUS:
      begin
         w[0]     = trans_result.idle;
         w[1]     = trans_result.entry_valid;
         w[3:2]   = trans_result.flag;
         w[15:8]  = trans_result.depth;
         w[16]    = trans_result.collision;
         w[17]    = trans_result.capture;
      end
      `REG_TRANS_EVAL_IN:  w = 32'($signed(trans_result.eval));
      `REG_TRANS_NODES_IN: w[`TRANS_NODES_WIDTH-1:0] = trans_result.nodes;
      `REG_TRANS_CMD:
         w[15:0] = {exp_trans_cmd.depth, 2'b00, exp_trans_cmd.clear,
                    exp_trans_cmd.hash_only, exp_trans_cmd.flag,
                    exp_trans_cmd.store, exp_trans_cmd.lookup};
      `REG_TRANS_EVAL:     w = {exp_trans_cmd.capture, 7'b0, exp_trans_cmd.eval};
      `REG_TRANS_NODES:    w[`TRANS_NODES_WIDTH-1:0] = exp_trans_cmd.nodes;
      default:
      begin
         if (index >= `REG_BOARD_BASE && index < `REG_BOARD_BASE + `BOARD_ROWS)
            w = exp_setup.board[index - `REG_BOARD_BASE];
         else if (index >= `REG_AM_BOARD_BASE && index < `REG_AM_BOARD_BASE + `BOARD_ROWS)
            w = move_info.board[index - `REG_AM_BOARD_BASE];
      end
   endcase
   r.raw = w;
   return r;
endfunction

`endif

// File: verif/engine_ctrl_tb.sv
/* Random register traffic from a fixed LFSR seed, checked against a shadow.
   One write or one read at a time, never overlapped. */
`timescale 1ns/100ps
`include "engine_ctrl_settings.svh"

module engine_ctrl_tb import engine_ctrl_pkg::*;
();

   localparam int OPS          = 400;
   localparam int RESET_CYCLES = 10;
   localparam int CYCLE_LIMIT  = OPS * 16 + RESET_CYCLES;
   localparam int NUM_INDICES  = 42;

   logic          clk = 1'b0;
   logic          rst;
   axil_wr_req_t  wr_req;
   axil_rd_req_t  rd_req;
   axil_wr_rsp_t  wr_rsp;
   axil_rd_rsp_t  rd_rsp;
   game_status_t  status;
   move_info_t    move_info;
   trans_result_t trans_result;
   board_setup_t  setup;
   logic          soft_reset;
   trans_cmd_t    trans_cmd;
   logic [31:0]   lfsr = 32'hd1c2;
   int            cycle_count = 0;

   // Mapped indices first and then unmapped neighbours
   int index_list [NUM_INDICES] = '{0, 1, 2, 3, 4, 8, 9, 10, 11, 12, 13, 14, 15,
      132, 133, 134, 135, 136, 172, 173, 174, 175, 176, 177, 178, 179,
      512, 514, 515, 520, 521, 525,
      5, 7, 16, 131, 137, 171, 180, 513, 519, 526};

   `include "engine_ctrl_model.svh"

   engine_ctrl_top dut (
      .clk          (clk),
      .rst          (rst),
      .wr_req       (wr_req),
      .rd_req       (rd_req),
      .wr_rsp       (wr_rsp),
      .rd_rsp       (rd_rsp),
      .status       (status),
      .move_info    (move_info),
      .trans_result (trans_result),
      .setup        (setup),
      .soft_reset   (soft_reset),
      .trans_cmd    (trans_cmd)
   );

   always #5 clk = !clk;

   task automatic fail_run();
      $display("ERRORS FOUND");
      $fatal(1, "run stopped at the first failure");
   endtask

   always @(posedge clk)
   begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= CYCLE_LIMIT)
      begin
         $display("Timeout after %0d cycles, a bus handshake never finished", cycle_count);
         fail_run();
      end
   end

   // Taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic rand_bit();
      lfsr = lfsr_step(lfsr);
      return lfsr[0];
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
         v = {v[30:0], rand_bit()};
      return v;
   endfunction

   function automatic logic [`REG_INDEX_WIDTH-1:0] pick_index();
      int k;
      if (rand_bits(3) == 0)
         return `REG_INDEX_WIDTH'(rand_bits(`REG_INDEX_WIDTH));  // Anywhere in the map
      k = int'(rand_bits(6)) % NUM_INDICES;
      return `REG_INDEX_WIDTH'(index_list[k]);
   endfunction

   task automatic check_word(input string name, input reg_word_u exp, input reg_word_u act);
      if (act !== exp)
      begin
         $display("ERR %s expected %h actual %h", name, exp, act);
         fail_run();
      end
   endtask

   task automatic check_setup(input string name, input board_setup_t exp,
                              input board_setup_t act);
      if (act !== exp)
      begin
         $display("ERR %s expected %h actual %h", name, exp, act);
         fail_run();
      end
   endtask

   task automatic check_trans_cmd(input string name, input trans_cmd_t exp,
                                  input trans_cmd_t act);
      if (act !== exp)
      begin
         $display("ERR %s expected %h actual %h", name, exp, act);
         fail_run();
      end
   endtask

   task automatic check_resp(input string name, input logic [1:0] exp, input logic [1:0] act);
      if (act !== exp)
      begin
         $display("ERR %s expected %h actual %h", name, exp, act);
         fail_run();
      end
   endtask

   task automatic check_level(input string name, input logic exp, input logic act);
      if (act !== exp)
      begin
         $display("ERR %s expected %b actual %b", name, exp, act);
         fail_run();
      end
   endtask

   task automatic randomize_inputs();
      logic [$bits(game_status_t)-1:0]  st_bits;
      logic [$bits(move_info_t)-1:0]    mi_bits;
      logic [$bits(trans_result_t)-1:0] tr_bits;
      for (int i = 0; i < $bits(game_status_t); i++)
         st_bits[i] = rand_bit();
      for (int i = 0; i < $bits(move_info_t); i++)
         mi_bits[i] = rand_bit();
      for (int i = 0; i < $bits(trans_result_t); i++)
         tr_bits[i] = rand_bit();
      status       = st_bits;
      move_info    = mi_bits;
      trans_result = tr_bits;
   endtask

   task automatic write_reg(input logic [`REG_INDEX_WIDTH-1:0] index, input reg_word_u data);
      int   order;
      int   skew;
      int   bdelay;
      int   step;
      logic aw_done;
      logic w_done;
      logic aw_taken;
      logic w_taken;
      order         = int'(rand_bits(2)) % 3;  // 0 address first, 1 data first
      skew          = int'(rand_bits(2));
      bdelay        = int'(rand_bits(2));
      wr_req.wstrb  = 4'(rand_bits(4));
      aw_done       = 1'b0;
      w_done        = 1'b0;
      step          = 0;
      while (!(aw_done && w_done))
      begin
         if (!aw_done && step >= ((order == 1) ? skew : 0))
         begin
            wr_req.awaddr  = {index, 2'b00};
            wr_req.awvalid = 1'b1;
         end
         if (!w_done && step >= ((order == 0) ? skew : 0))
         begin
            wr_req.wdata  = data.raw;
            wr_req.wvalid = 1'b1;
         end
         aw_taken = wr_req.awvalid && wr_rsp.awready;
         w_taken  = wr_req.wvalid && wr_rsp.wready;
         @(posedge clk);
         #1;
         if (aw_taken)
         begin
            aw_done        = 1'b1;
            wr_req.awvalid = 1'b0;
            check_level("awready while address held", 1'b0, wr_rsp.awready);
         end
         if (w_taken)
         begin
            w_done        = 1'b1;
            wr_req.wvalid = 1'b0;
            check_level("wready while data held", 1'b0, wr_rsp.wready);
         end
         step++;
      end
      while (!wr_rsp.bvalid)
      begin
         @(posedge clk);
         #1;
      end
      check_resp("write bresp", 2'b00, wr_rsp.bresp);
      model_write(int'(index), data.raw);
      repeat (bdelay)
      begin
         @(posedge clk);
         #1;
         if (!wr_rsp.bvalid)
         begin
            $display("Write response withdrawn before bready at index %0d", index);
            fail_run();
         end
      end
      wr_req.bready = 1'b1;
      @(posedge clk);
      #1;
      wr_req.bready = 1'b0;
      if (wr_rsp.bvalid)
      begin
         $display("Second write response after bready at index %0d", index);
         fail_run();
      end
      check_level($sformatf("awready after write %0d", index), 1'b1, wr_rsp.awready);
      check_level($sformatf("wready after write %0d", index), 1'b1, wr_rsp.wready);
      check_setup($sformatf("setup after write %0d", index), exp_setup, setup);
      check_level($sformatf("soft_reset after write %0d", index), exp_soft_reset, soft_reset);
      check_trans_cmd($sformatf("trans_cmd after write %0d", index), exp_trans_cmd,
                      trans_cmd);
   endtask

   task automatic read_reg(input logic [`REG_INDEX_WIDTH-1:0] index);
      reg_word_u expected;
      int        rdelay;
      rdelay         = int'(rand_bits(2));
      expected       = expected_read(int'(index));
      rd_req.araddr  = {index, 2'b00};
      rd_req.arvalid = 1'b1;
      check_level("arready", 1'b1, rd_rsp.arready);
      @(posedge clk);
      #1;
      rd_req.arvalid = 1'b0;
      while (!rd_rsp.rvalid)
      begin
         @(posedge clk);
         #1;
      end
      check_resp("read rresp", 2'b00, rd_rsp.rresp);
      check_word($sformatf("read index %0d", index), expected, rd_rsp.rdata);
      repeat (rdelay)
      begin
         @(posedge clk);
         #1;
         if (!rd_rsp.rvalid)
         begin
            $display("Read data withdrawn before rready at index %0d", index);
            fail_run();
         end
      end
      rd_req.rready = 1'b1;
      @(posedge clk);
      #1;
      rd_req.rready = 1'b0;
      if (rd_rsp.rvalid)
      begin
         $display("rvalid still high after rready at index %0d", index);
         fail_run();
      end
   endtask

   initial
   begin
      logic [`REG_INDEX_WIDTH-1:0] index;
      reg_word_u                   data;
      rst          = 1'b1;
      wr_req       = '0;
      rd_req       = '0;
      status       = '0;
      move_info    = '0;
      trans_result = '0;
      model_reset();
      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      rst = 1'b0;
      check_setup("reset setup", '0, setup);
      check_trans_cmd("reset trans_cmd", '0, trans_cmd);
      check_level("reset soft_reset", 1'b0, soft_reset);
      check_level("reset bvalid", 1'b0, wr_rsp.bvalid);
      check_level("reset rvalid", 1'b0, rd_rsp.rvalid);
      check_level("reset awready", 1'b1, wr_rsp.awready);
      check_level("reset wready", 1'b1, wr_rsp.wready);
      randomize_inputs();
      for (int op = 0; op < OPS; op++)
      begin
         if (rand_bits(2) == 0)
            randomize_inputs();  // Engine side moves on between operations
         index = pick_index();
         if (rand_bit())
         begin
            data.raw = rand_bits(32);
            write_reg(index, data);
         end
         else
            read_reg(index);
      end
      $display("NO ERRORS");
      $finish;
   end

endmodule

// File: verilog.f
+incdir+hw
+incdir+verif
hw/engine_ctrl_pkg.sv
hw/axil_write_port.sv
hw/board_setup_regs.sv
hw/trans_cmd_regs.sv
hw/reg_read_port.sv
hw/engine_ctrl_top.sv
verif/engine_ctrl_tb.sv

// File: Makefile
# Verilator flow for the engine host register block

VERILATOR  ?= verilator
TOP        ?= engine_ctrl_tb
FILELIST   ?= verilog.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= NO ERRORS
LINT_FLAGS ?= --lint-only -Wall -Wno-fatal --timing
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
